// ==== Bender.yml ====
package:
  name: la32_decode

dependencies: {}

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/la32_decode_pkg.sv
      - hw/la32_pipe_reg.sv
      - hw/la32_inst_decoder.sv
      - hw/la32_regfile.sv
      - hw/la32_decode_stage.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/la32_decode_assertions.sv
      - verification/tb_la32_decode_stage.sv

// ==== hw/la32_decode_config.svh ====
// LA32 decode stage configuration
// register file size, datapath width and the canonical NOP word

`ifndef LA32_DECODE_CONFIG_SVH
`define LA32_DECODE_CONFIG_SVH

// architectural integer registers
`define LA32_NUM_REGS 32

// data and address width
`define LA32_XLEN 32

// andi r0, r0, 0
`define LA32_INST_NOP 32'h0340_0000

`endif

// ==== hw/la32_decode_pkg.sv ====
// LA32 decode types
// fetch entry, micro-op, decoder output, issue bundle and writeback request

`include "la32_decode_config.svh"

package la32_decode_pkg;

    typedef struct packed {
        logic                  unknown;
        logic [`LA32_XLEN-1:0] badv;
        logic [6:0]            exception;
        logic [`LA32_XLEN-1:0] pc_next;
        logic [`LA32_XLEN-1:0] pc;
        logic [31:0]           inst;
    } fetch_entry_t;

    // one-hot instruction class that is all zero for nop or invalid
    typedef struct packed {
        logic br;
        logic bar;
        logic mem;
        logic csr;
        logic cache;
        logic idle;
        logic eret;
        logic tlb;
        logic mul;
        logic div;
        logic alu;
    } itype_t;

    typedef enum logic [1:0] {src1_rf, src1_pc, src1_zero, src1_cntid} src1_e;
    typedef enum logic [1:0] {src2_rf, src2_imm, src2_cntl, src2_cnth} src2_e;

    // 3R codes follow inst[18:15] and sra takes a free slot
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sub  = 4'b0010,
        alu_slt  = 4'b0100,
        alu_sltu = 4'b0101,
        alu_nor  = 4'b1000,
        alu_and  = 4'b1001,
        alu_or   = 4'b1010,
        alu_xor  = 4'b1011,
        alu_sra  = 4'b1100,
        alu_sll  = 4'b1110,
        alu_srl  = 4'b1111
    } alu_op_e;

    typedef struct packed {
        itype_t      itype;
        src1_e       src1;
        src2_e       src2;
        logic [3:0]  cond;
        logic        sign;
        logic        mem_atm;
        logic        privileged;
        logic [31:0] inst;
    } uop_t;

    typedef struct packed {
        uop_t                  uop;
        logic [`LA32_XLEN-1:0] imm;
        logic [4:0]            rd;
        logic [4:0]            rj;
        logic [4:0]            rk;
        logic [`LA32_XLEN-1:0] pc;
        logic [`LA32_XLEN-1:0] pc_next;
        logic [6:0]            exception;
        logic [`LA32_XLEN-1:0] badv;
        logic                  unknown;
        logic                  invalid_instruction;
        logic                  is_syscall;
        logic                  is_break;
        logic                  is_privileged;
    } decode_t;

    typedef struct packed {
        decode_t               dec;
        logic [`LA32_XLEN-1:0] rj_value;
        logic [`LA32_XLEN-1:0] rk_value;
    } issue_t;

    typedef struct packed {
        logic                  we;
        logic [4:0]            addr;
        logic [`LA32_XLEN-1:0] data;
    } wb_req_t;

endpackage

// ==== hw/la32_decode_stage.sv ====
// LA32 decode stage
// entry register, instruction decoder, register read and issue register;
// two edges from an accepted entry to the issue bundle

`timescale 1ns/1ps
`include "la32_decode_config.svh"

module la32_decode_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          stall,
    input  logic                          flush,
    input  logic                          in_valid,
    input  la32_decode_pkg::fetch_entry_t in_entry,
    input  la32_decode_pkg::wb_req_t      wb,
    output logic                          out_valid,
    output la32_decode_pkg::issue_t       out_issue
);
    import la32_decode_pkg::*;

    logic                  id_valid;
    fetch_entry_t          id_entry;
    decode_t               id_dec;
    logic [`LA32_XLEN-1:0] rj_value;
    logic [`LA32_XLEN-1:0] rk_value;
    issue_t                id_issue;

    la32_pipe_reg #(
        .payload_t (fetch_entry_t)
    ) i_entry_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_data   (in_entry),
        .out_valid (id_valid),
        .out_data  (id_entry)
    );

    la32_inst_decoder i_decoder (
        .entry (id_entry),
        .dec   (id_dec)
    );

    // only rj and rk are ever read
    la32_regfile i_regfile (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb      (wb),
        .raddr_a (id_dec.rj),
        .raddr_b (id_dec.rk),
        .rdata_a (rj_value),
        .rdata_b (rk_value)
    );

    assign id_issue = '{dec: id_dec, rj_value: rj_value, rk_value: rk_value};

    la32_pipe_reg #(
        .payload_t (issue_t)
    ) i_issue_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (id_valid),
        .in_data   (id_issue),
        .out_valid (out_valid),
        .out_data  (out_issue)
    );

endmodule

// ==== hw/la32_inst_decoder.sv ====
// LA32 instruction decoder
// combinational, classifies the instruction and builds the micro-op,
// immediate and register addresses; store and branch sources go to rk

`timescale 1ns/1ps
`include "la32_decode_config.svh"

module la32_inst_decoder (
    input  la32_decode_pkg::fetch_entry_t entry,
    output la32_decode_pkg::decode_t      dec
);
    import la32_decode_pkg::*;

    logic [31:0] inst;
    itype_t      cls;
    logic        is_b_or_bl;
    logic        is_jirl;
    logic        is_preload;
    logic        is_pcadd;
    logic        is_lui;
    logic        is_alu_imm;
    logic        is_invtlb;
    logic        is_ecall;
    logic        is_alu_sfti;
    logic        is_sra;
    logic        is_time;
    logic        is_alu3r;
    logic        mem_write;
    src1_e       src1;
    src2_e       src2;
    alu_op_e     alu_op;
    logic        alu_op_invalid;
    logic [3:0]  br_cond;
    logic        br_invalid;
    logic        invalid;
    logic        priv;
    logic [31:0] imm;

    assign inst = entry.inst;

    //////////////////////////////////////////////////
    // instruction class
    always_comb begin
        cls.br      = inst[30];
        cls.bar     = inst[30:16] == 15'b011100001110010;
        cls.mem     = inst[30:28] == 3'b010;
        cls.csr     = inst[30:24] == 7'b0000100;
        cls.cache   = inst[30:22] == 9'b000011000;
        cls.idle    = inst[30:15] == 16'b0000110010010001;
        cls.eret    = inst[30:10] == 21'b000011001001000001110;
        is_invtlb   = inst[30:15] == 16'b0000110010010011;
        // tlbsrch, tlbrd, tlbwr, tlbfill share a prefix with ertn
        cls.tlb     = is_invtlb ||
                      (inst[30:13] == 18'b000011001001000001 && inst[12:10] != 3'b110);
        cls.mul     = inst[30:17] == 14'b00000000001110;
        cls.div     = inst[30:17] == 14'b00000000010000;
        is_b_or_bl  = inst[30:27] == 4'b1010;
        is_jirl     = inst[30:26] == 5'b10011;
        is_preload  = inst[30:22] == 9'b010101011;
        is_pcadd    = inst[30:25] == 6'b001110;
        is_lui      = inst[30:25] == 6'b001010;
        is_alu_imm  = inst[30:25] == 6'b000001;
        is_ecall    = inst[30:17] == 14'b00000000010101 && !inst[15];
        is_alu_sfti = inst[30:20] == 11'b00000000100 && inst[17:15] == 3'b001;
        is_sra      = inst[30:15] == 16'b0000000000110000;
        is_time     = inst[30:11] == 20'b00000000000000001100;
        is_alu3r    = inst[30:19] == 12'b000000000010;
        cls.alu     = is_alu3r || is_time || is_sra || is_alu_sfti ||
                      is_alu_imm || is_pcadd || is_lui;
        mem_write   = cls.mem && inst[24];
    end

    //////////////////////////////////////////////////
    // operand sources
    always_comb begin
        if (is_lui) begin
            src1 = src1_zero;
        end else if (is_pcadd) begin
            src1 = src1_pc;
        end else if (is_time && !inst[10] && inst[4:0] == 5'd0) begin
            src1 = src1_cntid;
        end else begin
            src1 = src1_rf;
        end
    end

    always_comb begin
        if (is_alu_imm || is_alu_sfti || is_lui || is_pcadd) begin
            src2 = src2_imm;
        end else if (is_time) begin
            src2 = (!inst[10] && inst[4:0] != 5'd0) ? src2_cntl : src2_cnth;
        end else begin
            src2 = src2_rf;
        end
    end

    // alu operation with reserved sub-ops flagged
    always_comb begin
        alu_op         = alu_add;
        alu_op_invalid = 1'b0;
        if (is_alu3r) begin
            if (inst[18:15] inside {4'b0000, 4'b0010, 4'b0100, 4'b0101, 4'b1000,
                                    4'b1001, 4'b1010, 4'b1011, 4'b1110, 4'b1111}) begin
                alu_op = alu_op_e'(inst[18:15]);
            end else begin
                alu_op_invalid = 1'b1;
            end
        end else if (is_alu_imm) begin
            case (inst[24:22])
                3'b000:  alu_op = alu_slt;
                3'b001:  alu_op = alu_sltu;
                3'b010:  alu_op = alu_add;
                3'b101:  alu_op = alu_and;
                3'b110:  alu_op = alu_or;
                3'b111:  alu_op = alu_xor;
                default: alu_op_invalid = 1'b1;
            endcase
        end else if (is_alu_sfti) begin
            case (inst[19:18])
                2'b00:   alu_op = alu_sll;
                2'b01:   alu_op = alu_srl;
                2'b10:   alu_op = alu_sra;
                default: alu_op_invalid = 1'b1;
            endcase
        end else if (is_sra) begin
            alu_op = alu_sra;
        end
    end

    // jirl, b, bl, then beq through bgeu
    always_comb begin
        br_cond    = 4'd0;
        br_invalid = 1'b0;
        if (cls.br) begin
            br_cond    = inst[29:26];
            br_invalid = !(inst[29:26] inside {[4'b0011:4'b1011]});
        end
    end

    assign invalid = alu_op_invalid || br_invalid || inst[31] ||
                     (cls == '0 && !is_ecall) ||
                     (is_invtlb && inst[4:0] > 5'h6) ||
                     entry.exception != '0;

    assign priv = cls.cache || cls.tlb || cls.csr || cls.eret || cls.idle;

    //////////////////////////////////////////////////
    // immediate formats
    always_comb begin
        imm = '0;
        if (cls.cache || (is_alu_imm && !inst[24]) || (cls.mem && inst[27]) || is_alu_sfti)
            imm = {{20{inst[21]}}, inst[21:10]};
        if (is_alu_imm && inst[24])
            imm = {20'b0, inst[21:10]};
        if (cls.csr)
            imm = {{18{inst[23]}}, inst[23:10]};
        // ll and sc scale by four
        if (cls.mem && !inst[27])
            imm = {{16{inst[23]}}, inst[23:10], 2'b00};
        if (cls.br && !is_b_or_bl)
            imm = {{16{inst[25]}}, inst[25:10]};
        if (is_b_or_bl)
            imm = {{6{inst[9]}}, inst[9:0], inst[25:10]};
        if (is_pcadd || is_lui)
            imm = {inst[24:5], 12'b0};
    end

    //////////////////////////////////////////////////
    // output bundle
    always_comb begin
        dec.uop.itype      = (inst == `LA32_INST_NOP || invalid) ? '0 : cls;
        dec.uop.src1       = src1;
        dec.uop.src2       = src2;
        dec.uop.cond       = ({4{cls.alu}} & alu_op) |
                             {3'b0, cls.div & inst[15]} |
                             {3'b0, cls.mul & (inst[15] | inst[16])} |
                             ({4{cls.mem}} & {1'b0, inst[24], inst[27] ? inst[23:22] : 2'b10}) |
                             ({4{cls.br}} & br_cond);
        dec.uop.sign       = ((cls.mul | cls.div) & ~inst[16]) | (cls.mem & ~inst[25]);
        dec.uop.mem_atm    = ~inst[27];
        dec.uop.privileged = priv;
        dec.uop.inst       = inst;
        dec.imm            = imm;

        // bl links through r1
        if (cls.cache || cls.tlb || cls.idle || is_preload || (mem_write && inst[27]) ||
            (cls.br && !is_jirl && inst[29:26] != 4'b0101)) begin
            dec.rd = 5'd0;
        end else if (inst[30:26] == 5'b10101) begin
            dec.rd = 5'd1;
        end else begin
            dec.rd = inst[4:0] | ({5{is_time}} & inst[9:5]);
        end

        if ((cls.tlb && !is_invtlb) || cls.idle || is_pcadd || is_lui || is_b_or_bl || is_time)
            dec.rj = 5'd0;
        else
            dec.rj = inst[9:5];

        if (is_alu3r || is_sra || cls.mul || cls.div || is_invtlb)
            dec.rk = inst[14:10];
        else if (mem_write || (cls.br && !(is_b_or_bl || is_jirl)) || cls.csr)
            dec.rk = inst[4:0];
        else
            dec.rk = 5'd0;

        dec.pc                  = entry.pc;
        dec.pc_next             = entry.pc_next;
        dec.exception           = entry.exception;
        dec.badv                = entry.badv;
        dec.unknown             = entry.unknown;
        dec.invalid_instruction = invalid;
        dec.is_syscall          = is_ecall & inst[16];
        dec.is_break            = is_ecall & ~inst[16];
        // hit-type cacop is allowed in user mode
        dec.is_privileged       = priv && !(cls.cache && inst[4:3] == 2'd2);
    end

endmodule

// ==== hw/la32_pipe_reg.sv ====
// LA32 pipeline register
// valid-tagged stage register with stall hold and flush, any payload type

`timescale 1ns/1ps

module la32_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // flush wins over load, and also over stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves with the pipe
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== hw/la32_regfile.sv ====
// LA32 integer register file
// two combinational read ports, one write port, r0 hardwired to zero,
// write data bypassed to a read of the same address

`timescale 1ns/1ps
`include "la32_decode_config.svh"

module la32_regfile (
    input  logic                     clk,
    input  logic                     arst_n,
    input  la32_decode_pkg::wb_req_t wb,
    input  logic [4:0]               raddr_a,
    input  logic [4:0]               raddr_b,
    output logic [`LA32_XLEN-1:0]    rdata_a,
    output logic [`LA32_XLEN-1:0]    rdata_b
);

    logic [`LA32_XLEN-1:0] regs [`LA32_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LA32_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.addr != 5'd0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // r0 first, then same-cycle writeback
    assign rdata_a = (raddr_a == 5'd0)                 ? '0      :
                     (wb.we && wb.addr == raddr_a)     ? wb.data :
                                                         regs[raddr_a];
    assign rdata_b = (raddr_b == 5'd0)                 ? '0      :
                     (wb.we && wb.addr == raddr_b)     ? wb.data :
                                                         regs[raddr_b];

endmodule

// ==== verification/la32_decode_assertions.sv ====
// LA32 decode stage checker
// reference pipeline and shadow register file built from the stage ports,
// concurrent checks on the issue bundle

`timescale 1ns/1ps
`include "la32_decode_config.svh"

module la32_decode_assertions (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          stall,
    input logic                          flush,
    input logic                          in_valid,
    input la32_decode_pkg::fetch_entry_t in_entry,
    input la32_decode_pkg::wb_req_t      wb,
    input logic                          out_valid,
    input la32_decode_pkg::issue_t       out_issue
);
    import la32_decode_pkg::*;

    logic [`LA32_XLEN-1:0] shadow_rf [`LA32_NUM_REGS];
    logic [`LA32_XLEN-1:0] read_rf [`LA32_NUM_REGS];
    logic                  exp_v1;
    logic                  exp_v2;
    fetch_entry_t          exp_e1;
    fetch_entry_t          exp_e2;
    decode_t               dec;
    logic [31:0]           inst;
    logic [`LA32_XLEN-1:0] exp_rj_value;
    logic [`LA32_XLEN-1:0] exp_rk_value;
    logic [`LA32_XLEN-1:0] exp_addi_imm;
    logic [`LA32_XLEN-1:0] exp_bl_imm;
    logic                  is_addi;
    logic                  is_store_or_beq;
    logic                  is_bl;
    int                    fail_count = 0;

    //////////////////////////////////////////////////
    // reference model
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_v1 <= 1'b0;
            exp_v2 <= 1'b0;
        end else if (flush) begin
            exp_v1 <= 1'b0;
            exp_v2 <= 1'b0;
        end else if (!stall) begin
            exp_v1 <= in_valid;
            exp_v2 <= exp_v1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LA32_NUM_REGS; i++) begin
                shadow_rf[i] <= '0;
            end
        end else if (wb.we && wb.addr != 5'd0) begin
            shadow_rf[wb.addr] <= wb.data;
        end
    end

    // operands as seen during the decode cycle with writeback bypassed
    always_ff @(posedge clk) begin
        if (!stall) begin
            exp_e1 <= in_entry;
            exp_e2 <= exp_e1;
            for (int i = 0; i < `LA32_NUM_REGS; i++) begin
                read_rf[i] <= (wb.we && wb.addr == i) ? wb.data : shadow_rf[i];
            end
        end
    end

    assign dec             = out_issue.dec;
    assign inst            = exp_e2.inst;
    assign exp_rj_value    = (dec.rj == 5'd0) ? '0 : read_rf[dec.rj];
    assign exp_rk_value    = (dec.rk == 5'd0) ? '0 : read_rf[dec.rk];
    assign exp_addi_imm    = 32'($signed(inst[21:10]));
    assign exp_bl_imm      = 32'($signed({inst[9:0], inst[25:10]}));
    assign is_addi         = inst[31:22] == 10'b0000001010 && exp_e2.exception == '0;
    assign is_store_or_beq = inst[31:22] == 10'b0010100110 || inst[31:26] == 6'b010110;
    assign is_bl           = inst[31:26] == 6'b010101;

    //////////////////////////////////////////////////
    // checks
    valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == exp_v2)
    else begin
        fail_count++;
        $error("Error out_valid %h expected %h", $sampled(out_valid), $sampled(exp_v2));
    end

    pc_carried: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> dec.pc == exp_e2.pc && dec.pc_next == exp_e2.pc_next &&
        dec.uop.inst == exp_e2.inst)
    else begin
        fail_count++;
        $error("Error out_issue.dec.pc %h pc_next %h inst %h expected %h %h %h",
               $sampled(dec.pc), $sampled(dec.pc_next), $sampled(dec.uop.inst),
               $sampled(exp_e2.pc), $sampled(exp_e2.pc_next), $sampled(exp_e2.inst));
    end

    addi_decode: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && is_addi |-> dec.uop.itype.alu && dec.uop.src2 == src2_imm &&
        dec.imm == exp_addi_imm && dec.rd == inst[4:0] && dec.rj == inst[9:5])
    else begin
        fail_count++;
        $error("Error out_issue.dec.imm %h expected %h", $sampled(dec.imm),
               $sampled(exp_addi_imm));
    end

    operand_read: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> out_issue.rj_value == exp_rj_value &&
        out_issue.rk_value == exp_rk_value)
    else begin
        fail_count++;
        $error("Error rj_value %h rk_value %h expected %h %h",
               $sampled(out_issue.rj_value), $sampled(out_issue.rk_value),
               $sampled(exp_rj_value), $sampled(exp_rk_value));
    end

    store_branch_regs: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && is_store_or_beq |-> dec.rd == 5'd0 && dec.rk == inst[4:0])
    else begin
        fail_count++;
        $error("Error rd %h rk %h expected 00 %h", $sampled(dec.rd), $sampled(dec.rk),
               $sampled(inst[4:0]));
    end

    bl_link: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && is_bl |-> dec.rd == 5'd1 && dec.imm == exp_bl_imm)
    else begin
        fail_count++;
        $error("Error rd %h imm %h expected 01 %h", $sampled(dec.rd), $sampled(dec.imm),
               $sampled(exp_bl_imm));
    end

    invalid_flag: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && (inst[31] || exp_e2.exception != '0) |->
        dec.invalid_instruction && dec.uop.itype == '0)
    else begin
        fail_count++;
        $error("Error invalid_instruction %h itype %h expected 1 and 000",
               $sampled(dec.invalid_instruction), $sampled(dec.uop.itype));
    end

    stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        stall && !flush |=> $stable(out_valid) && $stable(out_issue))
    else begin
        fail_count++;
        $error("issue bundle changed while the stage was stalled");
    end

    flush_clear: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !out_valid)
    else begin
        fail_count++;
        $error("Error out_valid %h expected 0 after flush", $sampled(out_valid));
    end

endmodule

bind la32_decode_stage la32_decode_assertions i_la32_decode_assertions (
    .clk       (clk),
    .arst_n    (arst_n),
    .stall     (stall),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_entry  (in_entry),
    .wb        (wb),
    .out_valid (out_valid),
    .out_issue (out_issue)
);

// ==== verification/tb_la32_decode_stage.sv ====
// LA32 decode stage testbench
// reset, seeded stimulus per behavior and a final verdict;
// the bound checker module does the value checking

`timescale 1ns/1ps
`include "la32_decode_config.svh"

module tb_la32_decode_stage;
    import la32_decode_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic         clk;
    logic         arst_n;
    logic         stall;
    logic         flush;
    logic         in_valid;
    fetch_entry_t in_entry;
    wb_req_t      wb;
    logic         out_valid;
    issue_t       out_issue;

    int          tests_run;
    int          tests_failed;
    int          timeouts;
    int          test_timeouts;
    int          fails_at_start;
    logic [31:0] pc_count;

    la32_decode_stage i_la32_decode_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .stall     (stall),
        .flush     (flush),
        .in_valid  (in_valid),
        .in_entry  (in_entry),
        .wb        (wb),
        .out_valid (out_valid),
        .out_issue (out_issue)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // inputs move 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic send_entry(input logic [31:0] inst, input logic [6:0] exc);
        in_valid           = 1'b1;
        in_entry.inst      = inst;
        in_entry.pc        = pc_count;
        in_entry.pc_next   = pc_count + 32'd4;
        in_entry.exception = exc;
        in_entry.badv      = (exc != '0) ? pc_count : '0;
        in_entry.unknown   = 1'b0;
        pc_count           = pc_count + 32'd4;
        next_cycle();
        in_valid = 1'b0;
    endtask

    task automatic await_output();
        int n;
        n = 0;
        while (!out_valid && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!out_valid) begin
            $display("timeout: no valid issue bundle within %0d cycles", WAIT_LIMIT);
            test_timeouts++;
        end
    endtask

    // small address range so that reads often hit the write port
    task automatic random_writeback();
        wb.we   = ($urandom() % 4) != 0;
        wb.addr = 5'($urandom() % 8);
        wb.data = $urandom();
    endtask

    task automatic begin_test();
        fails_at_start = i_la32_decode_stage.i_la32_decode_assertions.fail_count;
        test_timeouts  = 0;
    endtask

    task automatic end_test(input string name);
        int fails;
        fails = i_la32_decode_stage.i_la32_decode_assertions.fail_count - fails_at_start;
        tests_run++;
        timeouts += test_timeouts;
        if (fails != 0 || test_timeouts != 0) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d assertion failures, %0d timeouts",
                     tests_run, name, fails, test_timeouts);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          k;

        void'($urandom(32'hd3b));
        arst_n       = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        in_valid     = 1'b0;
        in_entry     = '0;
        wb           = '0;
        tests_run    = 0;
        tests_failed = 0;
        timeouts     = 0;
        pc_count     = 32'h1c00_0000;
        repeat (3) @(posedge clk);
        #2 arst_n = 1'b1;
        next_cycle();

        begin_test();
        send_entry(`LA32_INST_NOP, 7'd0);
        await_output();
        end_test("reset_latency");

        begin_test();
        for (k = 0; k < 8; k++) begin
            r = $urandom();
            send_entry({10'b0000001010, r[21:0]}, 7'd0);
            await_output();
        end
        end_test("addi_w");

        //////////////////////////////////////////////////
        // operand reads while writebacks keep running
        begin_test();
        for (k = 0; k < 12; k++) begin
            random_writeback();
            next_cycle();
        end
        for (k = 0; k < 12; k++) begin
            r      = $urandom();
            r[9:8] = 2'b00;
            r[14:13] = 2'b00;
            if (k == 0) begin
                r[14:5] = '0;
            end
            random_writeback();
            send_entry({17'b00000000000100000, r[14:0]}, 7'd0);
            random_writeback();
            await_output();
        end
        wb = '0;
        end_test("operand_read");

        begin_test();
        for (k = 0; k < 4; k++) begin
            r = $urandom();
            send_entry({10'b0010100110, r[21:0]}, 7'd0);
            await_output();
            send_entry({6'b010110, r[25:0]}, 7'd0);
            await_output();
            send_entry({6'b010101, r[25:0]}, 7'd0);
            await_output();
        end
        end_test("store_branch");

        begin_test();
        for (k = 0; k < 4; k++) begin
            r = $urandom();
            send_entry({1'b1, r[30:0]}, 7'd0);
            await_output();
            send_entry({10'b0000001010, r[21:0]}, 7'h01 << k);
            await_output();
        end
        end_test("invalid_instruction");

        //////////////////////////////////////////////////
        // stall with both registers full, then flushes
        begin_test();
        send_entry(`LA32_INST_NOP, 7'd0);
        r = $urandom();
        send_entry({10'b0000001010, r[21:0]}, 7'd0);
        stall = 1'b1;
        repeat (3) next_cycle();
        stall = 1'b0;
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        repeat (2) next_cycle();
        send_entry(`LA32_INST_NOP, 7'd0);
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        repeat (3) next_cycle();
        end_test("stall_flush");

        $display("tests %0d, failed %0d, assertion failures %0d, timeouts %0d",
                 tests_run, tests_failed,
                 i_la32_decode_stage.i_la32_decode_assertions.fail_count, timeouts);
        if (tests_failed == 0 && timeouts == 0 &&
            i_la32_decode_stage.i_la32_decode_assertions.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+hw
hw/la32_decode_pkg.sv
hw/la32_pipe_reg.sv
hw/la32_inst_decoder.sv
hw/la32_regfile.sv
hw/la32_decode_stage.sv
verification/la32_decode_assertions.sv
verification/tb_la32_decode_stage.sv
